//--- dv/frame_writer_vectors.txt
# name  base address (hex)  w1  h1  err_burst
# err_burst is the B response answered with SLVERR, -1 for none
one_tile      0000000000001000 0 0 -1
row_of_four   0000000080000000 3 0 2
err_cleared   00000000000a0040 2 1 -1
column_of_5   00000001ffff0000 0 4 0
grid_4x3      fffffffffffff000 3 2 11
single_err    0000000000000070 0 0 0

//--- frame_writer.f
common/fw_pkg.sv
waddr/waddr_channel.sv
wdata/wdata_channel.sv
design/wresp_tracker.sv
design/frame_writer.sv
dv/frame_writer_chk.sv
dv/frame_writer_mon.sv
dv/frame_writer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it from the project root and checks the log.
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module frame_writer_tb \
    -f frame_writer.f -o frame_writer_sim > build.log 2>&1 \
    && ./obj_dir/frame_writer_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- dv/frame_writer_tb.sv
module frame_writer_tb;

    localparam int      FIFO_DEPTH   = 4;     // shallow so that pixel_full shows up often.

    logic               clk          = 1'b0;
    logic               rst_n        = 1'b0;
    logic               start_pulse  = 1'b0;
    fw_pkg::frame_cmd_t cmd          = '0;
    logic               pixel_valid  = 1'b0;
    fw_pkg::beat_t      pixel_data   = '0;
    logic               pixel_full;
    fw_pkg::aw_req_t    aw;
    logic               awvalid;
    logic               awready      = 1'b0;
    fw_pkg::w_beat_t    w;
    logic               wvalid;
    logic               wready       = 1'b0;
    logic               bvalid       = 1'b0;
    fw_pkg::axi_resp_t  bresp        = '0;
    logic               bready;
    logic               busy;
    logic               done;
    logic               resp_error;

    logic [127:0]       test_name    = '0;
    logic               err_expected = 1'b0;
    logic               end_test     = 1'b0;
    int                 passed;
    int                 failed;
    int                 aborts       = 0;     // timeouts and file problems.

    logic [15:0]        pix_lfsr     = 16'd71;
    logic [15:0]        rdy_lfsr     = 16'd71;
    int                 aw_seen      = 0;
    int                 w_bursts     = 0;     // bursts whose wlast went through.
    int                 b_sent       = 0;
    int                 b_base       = 0;     // b_sent when the test started.
    int                 err_burst    = -1;
    logic               b_taken      = 1'b0;

    frame_writer #(.FIFO_DEPTH(FIFO_DEPTH)) dut (.*);
    frame_writer_mon #(.FIFO_DEPTH(FIFO_DEPTH)) mon (.*);

    always #2 clk = ~clk;

    // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    ////////////////////
    // AXI slave model.
    ////////////////////

    always @(negedge clk) begin
        if (awvalid && awready) aw_seen++;
        if (wvalid && wready && w.wlast) w_bursts++;
        if (bvalid && bready) begin
            b_sent++;
            b_taken = 1'b1;
        end
    end

    always @(posedge clk) begin
        #1;
        rdy_lfsr = lfsr_step(rdy_lfsr);
        awready  = rdy_lfsr[0];
        rdy_lfsr = lfsr_step(rdy_lfsr);
        wready   = rdy_lfsr[0];
        if (!bvalid || b_taken) begin         // a pending response holds.
            bvalid = (b_sent < aw_seen) && (b_sent < w_bursts);
            bresp  = (b_sent - b_base == err_burst) ? 2'b10 : 2'b00;
        end
        b_taken = 1'b0;
    end

    ////////////////////
    // one frame.
    ////////////////////

    task automatic run_test(input logic [127:0] name, input logic [63:0] base,
                            input int w1, input int h1, input int err);
        int n_words;
        int sent;
        int waited;
        int i;
        n_words = 7 * (w1 + 1) * (h1 + 1);
        @(posedge clk);
        #1;
        test_name          = name;
        err_expected       = (err >= 0);
        err_burst          = err;
        b_base             = b_sent;
        cmd.target_address = base;
        cmd.w1             = fw_pkg::extent_t'(w1);
        cmd.h1             = fw_pkg::extent_t'(h1);
        start_pulse        = 1'b1;
        @(posedge clk);
        #1;
        start_pulse = 1'b0;
        sent        = 0;
        waited      = 0;
        while (sent < n_words && waited < 1000) begin
            pixel_valid = !pixel_full;        // never strobe into a full FIFO.
            if (!pixel_full) begin
                for (i = 0; i < 128; i++) begin
                    pix_lfsr      = lfsr_step(pix_lfsr);
                    pixel_data[i] = pix_lfsr[0];
                end
                sent++;
                waited = 0;
            end else begin
                waited++;
            end
            @(posedge clk);
            #1;
        end
        pixel_valid = 1'b0;
        waited      = 0;
        while (sent == n_words && !done && waited < 5000) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (sent < n_words) begin
            $display("%0s: pixel FIFO stayed full, the W channel stopped draining", name);
            aborts++;
        end else if (!done) begin
            $display("%0s: done never came after the last pixel word", name);
            aborts++;
        end else begin
            end_test = 1'b1;
            @(posedge clk);
            #1;
            end_test = 1'b0;
        end
    endtask

    initial begin
        int           fd;
        int           chk_fails;
        string        line;
        logic [127:0] name_v;
        logic [63:0]  base_v;
        int           w1_v;
        int           h1_v;
        int           err_v;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        fd = $fopen("dv/frame_writer_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/frame_writer_vectors.txt");
            aborts++;
        end
        while (fd != 0 && aborts == 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%s %h %d %d %d", name_v, base_v, w1_v, h1_v, err_v) == 5) begin
                run_test(name_v, base_v, w1_v, h1_v, err_v);
            end
        end
        chk_fails = dut.u_waddr.aw_chk.fail_count + dut.u_wdata.w_chk.fail_count;
        $display("tests passed %0d, failed %0d, aborted %0d, assertion failures %0d",
                 passed, failed, aborts, chk_fails);
        if (passed > 0 && failed == 0 && aborts == 0 && chk_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/frame_writer_mon.sv
module frame_writer_mon #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_pulse,
    input  fw_pkg::frame_cmd_t cmd,
    input  logic               pixel_valid,
    input  fw_pkg::beat_t      pixel_data,
    input  logic               pixel_full,
    input  fw_pkg::aw_req_t    aw,
    input  logic               awvalid,
    input  logic               awready,
    input  fw_pkg::w_beat_t    w,
    input  logic               wvalid,
    input  logic               wready,
    input  logic               bvalid,
    input  logic               bready,
    input  logic               busy,
    input  logic               done,
    input  logic               resp_error,
    input  logic [127:0]       test_name,       // ascii name padded with leading zeros.
    input  logic               err_expected,    // an SLVERR is sent in this test.
    input  logic               end_test,
    output int                 passed,
    output int                 failed
);

    logic [127:0] pix_q [$];                    // accepted words not yet seen on W.
    logic [63:0]  base;
    int           n_bursts;
    int           aw_cnt;
    int           w_cnt;
    int           b_cnt;
    int           done_cnt;
    int           errs = 0;
    logic         clear_pending = 1'b0;         // resp_error must drop after start.

    task automatic mismatch(input string what, input logic [127:0] exp,
                            input logic [127:0] act);
        $display("Error %0s %0s expected %0h actual %0h", test_name, what, exp, act);
        errs++;
    endtask

    initial begin
        passed = 0;
        failed = 0;
    end

    ////////////////////
    // sampled mid cycle where everything has settled.
    ////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            if (start_pulse) begin
                base          = cmd.target_address;
                n_bursts      = (int'(cmd.w1) + 1) * (int'(cmd.h1) + 1);
                aw_cnt        = 0;
                w_cnt         = 0;
                b_cnt         = 0;
                done_cnt      = 0;
                errs          = 0;
                clear_pending = 1'b1;
            end else if (clear_pending) begin
                if (resp_error !== 1'b0) mismatch("resp_error after start", 0, resp_error);
                clear_pending = 1'b0;
            end
            // the words still queued here are exactly the FIFO contents.
            if (pixel_full !== (pix_q.size() == FIFO_DEPTH)) begin
                mismatch("pixel_full", (pix_q.size() == FIFO_DEPTH), pixel_full);
            end
            if (awvalid && awready) begin       // bursts packed 7 x 16 bytes apart.
                if (aw.awaddr !== base + 64'(aw_cnt) * 64'd112) begin
                    mismatch("awaddr", base + 64'(aw_cnt) * 64'd112, aw.awaddr);
                end
                if (aw.awlen !== 8'd6) mismatch("awlen", 6, aw.awlen);
                aw_cnt++;
            end
            if (wvalid && wready) begin
                if (pix_q.size() == 0) begin
                    $display("%0s: W beat arrived with no pixel word left to send", test_name);
                    errs++;
                end else if (w.wdata !== pix_q[0]) begin
                    mismatch("wdata", pix_q[0], w.wdata);
                end
                if (pix_q.size() != 0) void'(pix_q.pop_front());
                if (w.wlast !== (w_cnt % 7 == 6)) mismatch("wlast", (w_cnt % 7 == 6), w.wlast);
                w_cnt++;
            end
            if (pixel_valid && !pixel_full) pix_q.push_back(pixel_data);
            if (bvalid && bready) b_cnt++;
            if (done) begin
                done_cnt++;
                if (b_cnt != n_bursts) mismatch("B responses before done", n_bursts, b_cnt);
                if (busy !== 1'b0) mismatch("busy at done", 0, busy);
                if (resp_error !== err_expected) mismatch("resp_error", err_expected, resp_error);
            end
            if (end_test) begin
                if (aw_cnt != n_bursts) mismatch("AW bursts", n_bursts, aw_cnt);
                if (w_cnt != 7 * n_bursts) mismatch("W beats", 7 * n_bursts, w_cnt);
                if (done_cnt != 1) mismatch("done pulses", 1, done_cnt);
                if (pix_q.size() != 0) begin
                    $display("%0s: %0d pixel words never left on W", test_name, pix_q.size());
                    errs++;
                end
                if (errs == 0) begin
                    passed++;
                    $display("%0s passed, %0d bursts", test_name, n_bursts);
                end else begin
                    failed++;
                    $display("%0s failed with %0d errors", test_name, errs);
                end
            end
        end
    end

endmodule

//--- dv/frame_writer_chk.sv
module frame_writer_chk #(
    parameter int PAYLOAD_BITS = 1
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    valid,
    input logic                    ready,
    input logic [PAYLOAD_BITS-1:0] payload
);

    int fail_count = 0;                         // read by the testbench at the end.

    // a stalled valid stays up until ready.
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid)
        else begin
            $error("valid dropped while ready was low");
            fail_count++;
        end

    // payload frozen during a stall.
    payload_held: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> $stable(payload))
        else begin
            $error("payload changed while valid waited for ready");
            fail_count++;
        end

endmodule

////////////////////
// one checker per channel.
////////////////////

bind waddr_channel frame_writer_chk #(.PAYLOAD_BITS($bits(fw_pkg::aw_req_t))) aw_chk (
    .clk(clk), .rst_n(rst_n), .valid(awvalid), .ready(awready), .payload(aw)
);

bind wdata_channel frame_writer_chk #(.PAYLOAD_BITS($bits(fw_pkg::w_beat_t))) w_chk (
    .clk(clk), .rst_n(rst_n), .valid(wvalid), .ready(wready), .payload(w)
);

//--- design/frame_writer.sv
module frame_writer #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst_n,

    // command.
    input  logic               start_pulse,
    input  fw_pkg::frame_cmd_t cmd,

    // pixel stream in.
    input  logic               pixel_valid,
    input  fw_pkg::beat_t      pixel_data,
    output logic               pixel_full,

    // AXI write address channel.
    output fw_pkg::aw_req_t    aw,
    output logic               awvalid,
    input  logic               awready,

    // AXI write data channel.
    output fw_pkg::w_beat_t    w,
    output logic               wvalid,
    input  logic               wready,

    // AXI write response channel.
    input  logic               bvalid,
    input  fw_pkg::axi_resp_t  bresp,
    output logic               bready,

    // status.
    output logic               busy,
    output logic               done,
    output logic               resp_error
);

    ////////////////////
    // three channels side by side, AW and W run unordered.
    ////////////////////

    waddr_channel u_waddr (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .cmd         (cmd),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready)
    );

    wdata_channel #(
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_wdata (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .pixel_full  (pixel_full),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready)
    );

    // derives the burst count from the same command.
    wresp_tracker u_wresp (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .cmd         (cmd),
        .bvalid      (bvalid),
        .bresp       (bresp),
        .bready      (bready),
        .busy        (busy),
        .done        (done),
        .resp_error  (resp_error)
    );

endmodule

//--- design/wresp_tracker.sv
module wresp_tracker (
    input  logic               clk,
    input  logic               rst_n,

    // local control.
    input  logic               start_pulse,
    input  fw_pkg::frame_cmd_t cmd,

    // AXI write response channel.
    input  logic               bvalid,
    input  fw_pkg::axi_resp_t  bresp,
    output logic               bready,

    // status.
    output logic               busy,
    output logic               done,
    output logic               resp_error
);

    logic [21:0]        tiles;        // (w1+1)*(h1+1), up to 2^20.
    fw_pkg::burst_cnt_t last_idx;     // index of the final B response.
    fw_pkg::burst_cnt_t b_cnt;        // B responses seen this frame.
    logic               b_fire;

    // count minus one fits the 20-bit counter even for 1024 x 1024.
    assign tiles  = (22'(cmd.w1) + 22'd1) * (22'(cmd.h1) + 22'd1);
    assign bready = busy;                 // accept responses only inside a frame.
    assign b_fire = bvalid && bready;

    always_ff @(posedge clk) begin
        if (start_pulse) begin
            last_idx <= fw_pkg::burst_cnt_t'(tiles - 22'd1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            resp_error <= 1'b0;
            b_cnt      <= '0;
        end else begin
            done <= 1'b0;                 // single-cycle pulse.
            if (start_pulse) begin
                busy       <= 1'b1;
                resp_error <= 1'b0;       // error flag is per frame.
                b_cnt      <= '0;
            end else if (b_fire) begin
                if (bresp != fw_pkg::OKAY) resp_error <= 1'b1;  // sticky.
                if (b_cnt == last_idx) begin
                    done <= 1'b1;         // busy falls with done.
                    busy <= 1'b0;
                end else begin
                    b_cnt <= b_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- wdata/wdata_channel.sv
module wdata_channel #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst_n,

    // pixel source, plain strobe.
    input  logic            pixel_valid,
    input  fw_pkg::beat_t   pixel_data,
    output logic            pixel_full,

    // AXI write data channel.
    output fw_pkg::w_beat_t w,
    output logic            wvalid,
    input  logic            wready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);      // holds 0 .. FIFO_DEPTH.

    typedef logic [PTR_W-1:0] ptr_t;                    // FIFO slot index.
    typedef logic [CNT_W-1:0] occ_t;                    // FIFO occupancy.
    typedef logic [2:0]       beat_idx_t;               // beat within a burst.

    fw_pkg::beat_t mem [FIFO_DEPTH];                    // pixel storage.
    ptr_t          wr_ptr;
    ptr_t          rd_ptr;
    occ_t          count;
    beat_idx_t     beat_cnt;
    logic          push;
    logic          pop;

    // circular increment, also for depths that are not a power of two.
    function automatic ptr_t ptr_next(input ptr_t p);
        ptr_next = (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    ////////////////////
    // flags and handshakes.
    ////////////////////

    assign pixel_full = (count == occ_t'(FIFO_DEPTH));
    assign wvalid     = (count != '0);                  // visible one cycle after push.

    assign push = pixel_valid && !pixel_full;           // a strobe on full is ignored.
    assign pop  = wvalid && wready;

    // head word stays put until popped, writes never touch its slot.
    assign w.wdata = mem[rd_ptr];
    assign w.wlast = (beat_cnt == beat_idx_t'(fw_pkg::BURST_BEATS - 1));

    ////////////////////
    // storage.
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pixel_data;
        end
    end

    ////////////////////
    // pointers and count.
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;         // write only.
                2'b01:   count <= count - 1'b1;         // read only.
                default: ;                              // both or neither.
            endcase
        end
    end

    // beat position, wraps after each wlast.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (pop) begin
            beat_cnt <= w.wlast ? '0 : beat_cnt + 1'b1;
        end
    end

endmodule

//--- waddr/waddr_channel.sv
module waddr_channel (
    input  logic               clk,
    input  logic               rst_n,

    // local control.
    input  logic               start_pulse,
    input  fw_pkg::frame_cmd_t cmd,

    // AXI write address channel.
    output fw_pkg::aw_req_t    aw,
    output logic               awvalid,
    input  logic               awready
);

    fw_pkg::aw_state_e  state;
    fw_pkg::aw_state_e  state_nxt;
    fw_pkg::frame_cmd_t cmd_q;         // command held for the whole frame.
    fw_pkg::extent_t    x;             // tile column of the next burst.
    fw_pkg::extent_t    y;             // tile row of the next burst.
    fw_pkg::addr_t      address;       // running burst address.
    logic               last_burst;    // burst in SEND is the final one.
    logic               first_burst;
    logic               row_end;
    logic               aw_fire;

    ////////////////////
    // channel outputs.
    ////////////////////

    assign awvalid   = (state == fw_pkg::AW_SEND);
    assign aw.awaddr = address;
    assign aw.awlen  = fw_pkg::BURST_LEN;       // every burst has the same length.

    assign aw_fire     = awvalid && awready;
    assign first_burst = (x == '0) && (y == '0); // x and y are cleared while idle.
    assign row_end     = (x == cmd_q.w1);

    ////////////////////
    // state machine.
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            fw_pkg::AW_IDLE: begin
                if (start_pulse) state_nxt = fw_pkg::AW_ADDR;
            end
            fw_pkg::AW_ADDR: begin
                state_nxt = fw_pkg::AW_SEND;    // address is ready next cycle.
            end
            fw_pkg::AW_SEND: begin
                // hold until accepted, then leave after the last tile.
                if (aw_fire) begin
                    state_nxt = last_burst ? fw_pkg::AW_IDLE : fw_pkg::AW_ADDR;
                end
            end
            default: state_nxt = fw_pkg::AW_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= fw_pkg::AW_IDLE;
            x          <= '0;
            y          <= '0;
            last_burst <= 1'b0;
        end else begin
            state <= state_nxt;
            case (state)
                fw_pkg::AW_IDLE: begin
                    x          <= '0;   // walk restarts at tile (0,0).
                    y          <= '0;
                    last_burst <= 1'b0;
                end
                fw_pkg::AW_ADDR: begin
                    // row-major walk, x wraps at w1 and bumps y.
                    last_burst <= row_end && (y == cmd_q.h1);
                    x          <= row_end ? '0 : x + 1'b1;
                    y          <= row_end ? y + 1'b1 : y;
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // payload.
    ////////////////////

    always_ff @(posedge clk) begin
        if (state == fw_pkg::AW_IDLE && start_pulse) begin
            cmd_q <= cmd;                       // latched once per frame.
        end
        if (state == fw_pkg::AW_ADDR) begin
            address <= first_burst ? cmd_q.target_address
                                   : address + fw_pkg::BURST_STRIDE;
        end
    end

endmodule

//--- common/fw_pkg.sv
package fw_pkg;

    ////////////////////
    // widths with a meaning.
    ////////////////////

    parameter int BEAT_BITS = 128;                  // one pixel word per W beat.

    typedef logic [63:0]          addr_t;           // byte address on the bus.
    typedef logic [9:0]           extent_t;         // tile index, also w1 and h1.
    typedef logic [19:0]          burst_cnt_t;      // bursts in one frame.
    typedef logic [BEAT_BITS-1:0] beat_t;           // pixel word.
    typedef logic [1:0]           axi_resp_t;       // B channel response code.

    localparam axi_resp_t OKAY = 2'b00;             // every other code counts as an error.

    ////////////////////
    // burst shape.
    ////////////////////

    localparam logic [7:0] BURST_LEN   = 8'd6;                 // awlen, beats minus one.
    localparam int         BURST_BEATS = int'(BURST_LEN) + 1;  // 7 beats per burst.

    // bursts sit back to back in memory, 7 x 16 bytes apart.
    localparam addr_t BURST_STRIDE = addr_t'(BURST_BEATS * (BEAT_BITS / 8));

    ////////////////////
    // address FSM and bundles.
    ////////////////////

    typedef enum logic [1:0] {
        AW_IDLE,                                    // waiting for start.
        AW_ADDR,                                    // compute next burst address.
        AW_SEND                                     // awvalid high until accepted.
    } aw_state_e;

    typedef struct packed {
        addr_t      awaddr;
        logic [7:0] awlen;
    } aw_req_t;

    typedef struct packed {
        beat_t wdata;
        logic  wlast;
    } w_beat_t;

    typedef struct packed {
        addr_t   target_address;                    // base of the frame.
        extent_t w1;                                // last tile column.
        extent_t h1;                                // last tile row.
    } frame_cmd_t;

endpackage
